// File: tests/psx_pad_tests.dat
# columns: mode pad_id btn_lo btn_hi, all hex
# mode 0 is a normal frame, mode k withholds the pad ack after byte k
0 41 ff ff
0 41 fe ff
0 73 7f bf
2 41 00 00
0 41 ef fd
1 41 ff ff
0 41 55 aa
3 73 12 34
0 41 aa 55
4 41 00 ff
0 73 00 00
0 41 ff 00
0 41 3c c3
0 41 ff fe

// File: list.f
design/psx_proto_pkg.sv
design/psx_timing_pkg.sv
design/psx_byte_xfer.sv
design/psx_ack_watch.sv
design/psx_poll_seq.sv
design/psx_pad_host.sv
tests/psx_pad_model.sv
tests/tb_psx_pad_host.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the pad host testbench with Verilator
cd "$(dirname "$0")" || exit 1

top=tb_psx_pad_host
log=sim.log

verilator --binary --timing --timescale 1ns/10ps -f list.f --top-module "$top"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/V"$top" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "NO ERRORS" "$log"; then
    echo "simulation passed"
    exit 0
fi
echo "pass message missing from $log"
exit 1

// File: tests/tb_psx_pad_host.sv
`timescale 1ns/10ps

module tb_psx_pad_host;

    localparam psx_timing_pkg::cycles_t BOOT_CYCLES     = 20;
    localparam psx_timing_pkg::cycles_t ATT_HIGH_CYCLES = 12;
    localparam psx_timing_pkg::cycles_t BYTE_GAP_CYCLES = 6;
    localparam psx_timing_pkg::cycles_t HALF_BIT_CYCLES = 2;
    localparam psx_timing_pkg::cycles_t ACK_TIMEOUT     = 24;
    // every ack taking its whole window
    localparam psx_timing_pkg::cycles_t FRAME_MAX = 5 * (BYTE_GAP_CYCLES + 16 * HALF_BIT_CYCLES)
        + 4 * (ACK_TIMEOUT + 4) + ATT_HIGH_CYCLES + 4;

    typedef struct packed {
        psx_proto_pkg::byte_t mode;  // 0 normal, k drops the ack after byte k
        psx_proto_pkg::byte_t pad_id;
        psx_proto_pkg::byte_t btn_lo;
        psx_proto_pkg::byte_t btn_hi;
    } test_vec_t;

    logic                       clk;
    logic                       rst_n;
    logic                       data;
    logic                       ack;
    logic                       psx_clk;
    logic                       cmd;
    logic                       att;
    psx_proto_pkg::pad_report_t report;
    logic                       report_valid;
    logic                       pad_lost;
    test_vec_t                  cur;
    psx_proto_pkg::byte_t       nbytes;
    psx_proto_pkg::byte_t [4:0] cmd_seen;
    psx_proto_pkg::byte_t       rv_count;
    psx_timing_pkg::cycles_t    cycle_cnt;
    psx_timing_pkg::cycles_t    cycle_limit;
    string                      test_name;
    test_vec_t                  tests[$];

    psx_pad_host #(
        .BOOT_CYCLES    (BOOT_CYCLES),
        .ATT_HIGH_CYCLES(ATT_HIGH_CYCLES),
        .BYTE_GAP_CYCLES(BYTE_GAP_CYCLES),
        .HALF_BIT_CYCLES(HALF_BIT_CYCLES),
        .ACK_TIMEOUT    (ACK_TIMEOUT)
    ) dut0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .data        (data),
        .ack         (ack),
        .psx_clk     (psx_clk),
        .cmd         (cmd),
        .att         (att),
        .report      (report),
        .report_valid(report_valid),
        .pad_lost    (pad_lost)
    );

    psx_pad_model #(
        .ACK_DELAY(HALF_BIT_CYCLES + 4)
    ) pad0 (
        .clk     (clk),
        .att     (att),
        .psx_clk (psx_clk),
        .cmd     (cmd),
        .mode    (cur.mode),
        .pad_id  (cur.pad_id),
        .btn_lo  (cur.btn_lo),
        .btn_hi  (cur.btn_hi),
        .data    (data),
        .ack     (ack),
        .nbytes  (nbytes),
        .cmd_seen(cmd_seen)
    );

    task automatic abort_run();
        $display("ERRORS FOUND");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_report(input string name, input psx_proto_pkg::pad_report_t exp,
                                input psx_proto_pkg::pad_report_t got);
        if (got !== exp) begin
            $display("Error %s report: expected %h, got %h", name, exp, got);
            abort_run();
        end
    endtask

    task automatic check_byte(input string name, input psx_proto_pkg::byte_t exp,
                              input psx_proto_pkg::byte_t got);
        if (got !== exp) begin
            $display("Error %s: expected %h, got %h", name, exp, got);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic got);
        if (got !== exp) begin
            $display("Error %s: expected %b, got %b", name, exp, got);
            abort_run();
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        cycle_cnt = '0;
        forever begin
            @(posedge clk);
            cycle_cnt = cycle_cnt + 1;
            if (cycle_limit != 0 && cycle_cnt > cycle_limit) begin
                $display("timeout, frames still running after %0d cycles", cycle_cnt);
                abort_run();
            end
        end
    end

    // idle bus while att is high, count of report strobes
    initial begin
        rv_count = '0;
        forever begin
            @(negedge clk);
            if (rst_n === 1'b1) begin
                if (report_valid) begin
                    rv_count = rv_count + 8'd1;
                end
                if (att) begin
                    check_flag({test_name, " psx_clk idle"}, 1'b1, psx_clk);
                    check_flag({test_name, " cmd idle"}, 1'b1, cmd);
                end
            end
        end
    end

    initial begin
        int                   fd;
        int                   code;
        string                line;
        psx_proto_pkg::byte_t m;
        psx_proto_pkg::byte_t id;
        psx_proto_pkg::byte_t lo;
        psx_proto_pkg::byte_t hi;
        test_vec_t            tv;
        psx_proto_pkg::byte_t normals;
        logic [39:0]          exp_cmd;
        logic [39:0]          got_cmd;

        rst_n       = 1'b0;
        cur         = '0;
        cycle_limit = '0;
        normals     = '0;
        test_name   = "reset";
        fd = $fopen("tests/psx_pad_tests.dat", "r");
        if (fd == 0) begin
            $display("cannot open tests/psx_pad_tests.dat");
            abort_run();
        end
        while (!$feof(fd)) begin
            line = "";
            code = $fgets(line, fd);
            if (code != 0 && $sscanf(line, "%h %h %h %h", m, id, lo, hi) == 4) begin
                tv.mode   = m;
                tv.pad_id = id;
                tv.btn_lo = lo;
                tv.btn_hi = hi;
                tests.push_back(tv);
            end
        end
        $fclose(fd);
        if (tests.size() == 0) begin
            $display("no test lines found in tests/psx_pad_tests.dat");
            abort_run();
        end
        cycle_limit = BOOT_CYCLES + tests.size() * 2 * FRAME_MAX;

        repeat (5) @(posedge clk);
        #10;
        rst_n = 1'b1;
        @(negedge clk);
        check_flag("reset att", 1'b1, att);
        check_flag("reset psx_clk", 1'b1, psx_clk);
        check_flag("reset cmd", 1'b1, cmd);
        check_flag("reset report_valid", 1'b0, report_valid);
        check_flag("reset pad_lost", 1'b0, pad_lost);

        for (int i = 0; i < tests.size(); i++) begin
            @(posedge clk);
            #10;
            cur       = tests[i];
            test_name = $sformatf("frame %0d", i);
            do begin
                @(negedge clk);
            end while (!report_valid && !pad_lost);
            check_flag({test_name, " report_valid"}, cur.mode == 8'd0, report_valid);
            check_flag({test_name, " pad_lost"}, cur.mode != 8'd0, pad_lost);
            if (cur.mode == 8'd0) begin
                normals = normals + 8'd1;
                check_report(test_name, {cur.pad_id, cur.btn_hi, cur.btn_lo}, report);
                check_byte({test_name, " bytes seen"}, 8'd5, nbytes);
                exp_cmd = {8'h00, 8'h00, 8'h00, 8'h42, 8'h01};  // first byte lowest
                got_cmd = cmd_seen;
                for (int b = 0; b < 5; b++) begin
                    check_byte($sformatf("%s cmd byte %0d", test_name, b + 1),
                               exp_cmd[7:0], got_cmd[7:0]);
                    exp_cmd = exp_cmd >> 8;
                    got_cmd = got_cmd >> 8;
                end
            end else begin
                check_byte({test_name, " bytes seen"}, cur.mode, nbytes);
            end
            @(negedge clk);
            check_flag({test_name, " strobe width"}, 1'b0, report_valid | pad_lost);
            check_byte({test_name, " report count"}, normals, rv_count);
        end
        $display("NO ERRORS");
        $finish;
    end

endmodule

// File: tests/psx_pad_model.sv
`timescale 1ns/10ps

module psx_pad_model #(
    parameter int ACK_DELAY = 6  // cycles from last psx_clk rise to ack low
) (
    input  logic                        clk,
    input  logic                        att,
    input  logic                        psx_clk,
    input  logic                        cmd,
    input  psx_proto_pkg::byte_t        mode,
    input  psx_proto_pkg::byte_t        pad_id,
    input  psx_proto_pkg::byte_t        btn_lo,
    input  psx_proto_pkg::byte_t        btn_hi,
    output logic                        data,
    output logic                        ack,
    output psx_proto_pkg::byte_t        nbytes,
    output psx_proto_pkg::byte_t [4:0]  cmd_seen  // first byte in [0] after five bytes
);

    psx_proto_pkg::byte_t mode_q;
    psx_proto_pkg::byte_t id_q;
    psx_proto_pkg::byte_t lo_q;
    psx_proto_pkg::byte_t hi_q;
    psx_proto_pkg::byte_t resp_sh;
    psx_proto_pkg::byte_t cmd_sh;
    logic                 att_q;
    logic                 clk_q;
    int                   bit_cnt;
    int                   ack_cnt;

    // pad answer for each frame byte, counted from zero
    function automatic psx_proto_pkg::byte_t pick_resp(input psx_proto_pkg::byte_t n);
        case (n)
            8'd1:    return id_q;
            8'd2:    return 8'h5a;  // ready marker, not part of the report
            8'd3:    return lo_q;
            8'd4:    return hi_q;
            default: return 8'hff;
        endcase
    endfunction

    initial begin
        data     = 1'b1;
        ack      = 1'b1;
        nbytes   = '0;
        cmd_seen = '0;
        att_q    = 1'b1;
        clk_q    = 1'b1;
        bit_cnt  = 0;
        ack_cnt  = 0;
        forever begin
            @(posedge clk);
            #10;
            if (ack_cnt != 0) begin
                ack_cnt = ack_cnt + 1;
                if (ack_cnt == ACK_DELAY) begin
                    ack = 1'b0;
                end else if (ack_cnt == ACK_DELAY + 2) begin
                    ack     = 1'b1;  // two cycle pulse
                    ack_cnt = 0;
                end
            end
            if (att_q && !att) begin
                mode_q   = mode;
                id_q     = pad_id;
                lo_q     = btn_lo;
                hi_q     = btn_hi;
                nbytes   = '0;
                cmd_seen = '0;
                bit_cnt  = 0;
            end
            if (att) begin
                data = 1'b1;
            end else if (clk_q && !psx_clk) begin
                if (bit_cnt == 0) begin
                    resp_sh = pick_resp(nbytes);
                end
                data    = resp_sh[0];
                resp_sh = resp_sh >> 1;
            end else if (!clk_q && psx_clk) begin
                cmd_sh  = {cmd, cmd_sh[7:1]};  // lsb arrives first
                bit_cnt = bit_cnt + 1;
                if (bit_cnt == 8) begin
                    bit_cnt  = 0;
                    cmd_seen = {cmd_sh, cmd_seen[4:1]};
                    nbytes   = nbytes + 8'd1;
                    if (nbytes <= 8'd4 && nbytes != mode_q) begin
                        ack_cnt = 1;
                    end
                end
            end
            att_q = att;
            clk_q = psx_clk;
        end
    end

endmodule

// File: design/psx_pad_host.sv
`timescale 1ns/10ps

module psx_pad_host #(
    parameter psx_timing_pkg::cycles_t BOOT_CYCLES     = 16000000,  // 8 s at 500 ns
    parameter psx_timing_pkg::cycles_t ATT_HIGH_CYCLES = 250,
    parameter psx_timing_pkg::cycles_t BYTE_GAP_CYCLES = 14,
    parameter psx_timing_pkg::cycles_t HALF_BIT_CYCLES = 4,
    parameter psx_timing_pkg::cycles_t ACK_TIMEOUT     = 120        // 60 us
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       data,
    input  logic                       ack,
    output logic                       psx_clk,
    output logic                       cmd,
    output logic                       att,
    output psx_proto_pkg::pad_report_t report,
    output logic                       report_valid,
    output logic                       pad_lost
);

    psx_proto_pkg::byte_t tx_byte;
    psx_proto_pkg::byte_t rx_byte;
    logic                 xfer_start;
    logic                 xfer_done;
    logic                 ack_arm;
    logic                 ack_ok;
    logic                 ack_late;

    psx_poll_seq #(
        .BOOT_CYCLES    (BOOT_CYCLES),
        .ATT_HIGH_CYCLES(ATT_HIGH_CYCLES)
    ) seq0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .xfer_done   (xfer_done),
        .rx_byte     (rx_byte),
        .ack_ok      (ack_ok),
        .ack_late    (ack_late),
        .xfer_start  (xfer_start),
        .tx_byte     (tx_byte),
        .ack_arm     (ack_arm),
        .att         (att),
        .report      (report),
        .report_valid(report_valid),
        .pad_lost    (pad_lost)
    );

    psx_byte_xfer #(
        .BYTE_GAP_CYCLES(BYTE_GAP_CYCLES),
        .HALF_BIT_CYCLES(HALF_BIT_CYCLES)
    ) xfer0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .xfer_start(xfer_start),
        .tx_byte   (tx_byte),
        .data      (data),
        .psx_clk   (psx_clk),
        .cmd       (cmd),
        .rx_byte   (rx_byte),
        .xfer_done (xfer_done)
    );

    psx_ack_watch #(
        .ACK_TIMEOUT(ACK_TIMEOUT)
    ) ack0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .ack_arm (ack_arm),
        .ack     (ack),
        .ack_ok  (ack_ok),
        .ack_late(ack_late)
    );

endmodule

// File: design/psx_poll_seq.sv
`timescale 1ns/10ps

module psx_poll_seq #(
    parameter psx_timing_pkg::cycles_t BOOT_CYCLES     = 16000000,
    parameter psx_timing_pkg::cycles_t ATT_HIGH_CYCLES = 250
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       xfer_done,
    input  psx_proto_pkg::byte_t       rx_byte,
    input  logic                       ack_ok,
    input  logic                       ack_late,
    output logic                       xfer_start,
    output psx_proto_pkg::byte_t       tx_byte,
    output logic                       ack_arm,
    output logic                       att,
    output psx_proto_pkg::pad_report_t report,
    output logic                       report_valid,
    output logic                       pad_lost
);

    psx_timing_pkg::poll_state_t state;
    psx_timing_pkg::cycles_t     wait_cnt;
    psx_proto_pkg::slot_t        slot;
    psx_proto_pkg::byte_t        pad_id_r;
    psx_proto_pkg::byte_t        btn_lo_r;
    logic                        byte_in;

    function automatic psx_proto_pkg::byte_t slot_cmd(input psx_proto_pkg::slot_t s);
        psx_proto_pkg::byte_t c;
        case (s)
            psx_proto_pkg::SLOT_START: c = psx_proto_pkg::CMD_START;
            psx_proto_pkg::SLOT_ID:    c = psx_proto_pkg::CMD_POLL;
            default:                   c = psx_proto_pkg::CMD_IDLE;
        endcase
        return c;
    endfunction

    // slot changes with xfer_start, so the byte is ready when it fires
    assign tx_byte = slot_cmd(slot);
    assign byte_in = (state == psx_timing_pkg::ST_XFER) && xfer_done;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= psx_timing_pkg::ST_BOOT;
            wait_cnt     <= '0;
            slot         <= '0;
            att          <= 1'b1;
            xfer_start   <= 1'b0;
            ack_arm      <= 1'b0;
            report_valid <= 1'b0;
            pad_lost     <= 1'b0;
        end else begin
            xfer_start   <= 1'b0;
            ack_arm      <= 1'b0;
            report_valid <= 1'b0;
            pad_lost     <= 1'b0;
            case (state)
                psx_timing_pkg::ST_BOOT: begin
                    if (wait_cnt >= BOOT_CYCLES - 1) begin
                        att   <= 1'b0;
                        state <= psx_timing_pkg::ST_ATT_LOW;
                    end else begin
                        wait_cnt <= wait_cnt + 1;
                    end
                end
                psx_timing_pkg::ST_ATT_HIGH: begin
                    if (wait_cnt >= ATT_HIGH_CYCLES - 1) begin
                        att   <= 1'b0;
                        state <= psx_timing_pkg::ST_ATT_LOW;
                    end else begin
                        wait_cnt <= wait_cnt + 1;
                    end
                end
                psx_timing_pkg::ST_ATT_LOW: begin
                    slot       <= psx_proto_pkg::SLOT_START;
                    xfer_start <= 1'b1;
                    state      <= psx_timing_pkg::ST_XFER;
                end
                psx_timing_pkg::ST_XFER: begin
                    if (xfer_done) begin
                        if (slot == psx_proto_pkg::LAST_SLOT) begin
                            report_valid <= 1'b1;
                            att          <= 1'b1;
                            wait_cnt     <= '0;
                            state        <= psx_timing_pkg::ST_ATT_HIGH;
                        end else begin
                            ack_arm <= 1'b1;
                            state   <= psx_timing_pkg::ST_ACK_WAIT;
                        end
                    end
                end
                psx_timing_pkg::ST_ACK_WAIT: begin
                    if (ack_ok) begin
                        slot       <= slot + 3'd1;
                        xfer_start <= 1'b1;
                        state      <= psx_timing_pkg::ST_XFER;
                    end else if (ack_late) begin
                        // pad gone quiet, drop the frame
                        pad_lost <= 1'b1;
                        att      <= 1'b1;
                        wait_cnt <= '0;
                        state    <= psx_timing_pkg::ST_ATT_HIGH;
                    end
                end
                default: begin
                    att      <= 1'b1;
                    wait_cnt <= '0;
                    state    <= psx_timing_pkg::ST_ATT_HIGH;
                end
            endcase
        end
    end

    // received bytes, report updated together with report_valid
    always_ff @(posedge clk) begin
        if (byte_in) begin
            if (slot == psx_proto_pkg::SLOT_ID) begin
                pad_id_r <= rx_byte;
            end
            if (slot == psx_proto_pkg::SLOT_BTN_LO) begin
                btn_lo_r <= rx_byte;
            end
            if (slot == psx_proto_pkg::LAST_SLOT) begin
                report.pad_id  <= pad_id_r;
                report.buttons <= {rx_byte, btn_lo_r};
            end
        end
    end

endmodule

// File: design/psx_ack_watch.sv
`timescale 1ns/10ps

module psx_ack_watch #(
    parameter psx_timing_pkg::cycles_t ACK_TIMEOUT = 120
) (
    input  logic clk,
    input  logic rst_n,
    input  logic ack_arm,
    input  logic ack,
    output logic ack_ok,
    output logic ack_late
);

    logic                    armed;
    psx_timing_pkg::cycles_t win_cnt;  // cycles since ack_arm

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            armed    <= 1'b0;
            win_cnt  <= '0;
            ack_ok   <= 1'b0;
            ack_late <= 1'b0;
        end else begin
            ack_ok   <= 1'b0;
            ack_late <= 1'b0;
            if (ack_arm) begin
                armed   <= 1'b1;
                win_cnt <= 1;
            end else if (armed) begin
                if (!ack) begin
                    armed  <= 1'b0;
                    ack_ok <= 1'b1;
                end else if (win_cnt >= ACK_TIMEOUT - 1) begin
                    armed    <= 1'b0;
                    ack_late <= 1'b1;  // lands ACK_TIMEOUT after arm
                end else begin
                    win_cnt <= win_cnt + 1;
                end
            end
        end
    end

endmodule

// File: design/psx_byte_xfer.sv
`timescale 1ns/10ps

module psx_byte_xfer #(
    parameter psx_timing_pkg::cycles_t BYTE_GAP_CYCLES = 14,
    parameter psx_timing_pkg::cycles_t HALF_BIT_CYCLES = 4
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 xfer_start,
    input  psx_proto_pkg::byte_t tx_byte,
    input  logic                 data,
    output logic                 psx_clk,
    output logic                 cmd,
    output psx_proto_pkg::byte_t rx_byte,
    output logic                 xfer_done
);

    typedef enum logic [1:0] {PH_IDLE, PH_GAP, PH_LOW, PH_HIGH} phase_t;

    phase_t                  phase;
    psx_timing_pkg::cycles_t phase_cnt;
    psx_proto_pkg::bit_idx_t bit_cnt;
    psx_proto_pkg::byte_t    tx_shift;
    logic                    half_end;
    logic                    clk_rise;
    logic                    next_bit;

    assign half_end = (phase_cnt == HALF_BIT_CYCLES - 1);
    assign clk_rise = (phase == PH_LOW) && half_end;
    assign next_bit = (phase == PH_HIGH) && half_end && (bit_cnt != psx_proto_pkg::LAST_BIT);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase     <= PH_IDLE;
            phase_cnt <= '0;
            bit_cnt   <= '0;
            psx_clk   <= 1'b1;
            cmd       <= 1'b1;
            xfer_done <= 1'b0;
        end else begin
            xfer_done <= 1'b0;
            case (phase)
                PH_IDLE: begin
                    if (xfer_start) begin
                        bit_cnt <= '0;
                        // start cycle already counts as the first gap cycle
                        if (BYTE_GAP_CYCLES > 1) begin
                            phase     <= PH_GAP;
                            phase_cnt <= 1;
                        end else begin
                            phase     <= PH_LOW;
                            phase_cnt <= '0;
                            psx_clk   <= 1'b0;
                            cmd       <= tx_byte[0];
                        end
                    end
                end
                PH_GAP: begin
                    if (phase_cnt == BYTE_GAP_CYCLES - 1) begin
                        phase     <= PH_LOW;
                        phase_cnt <= '0;
                        psx_clk   <= 1'b0;
                        cmd       <= tx_shift[0];
                    end else begin
                        phase_cnt <= phase_cnt + 1;
                    end
                end
                PH_LOW: begin
                    if (half_end) begin
                        phase     <= PH_HIGH;
                        phase_cnt <= '0;
                        psx_clk   <= 1'b1;  // pad data taken on this edge
                    end else begin
                        phase_cnt <= phase_cnt + 1;
                    end
                end
                PH_HIGH: begin
                    if (half_end) begin
                        phase_cnt <= '0;
                        if (bit_cnt == psx_proto_pkg::LAST_BIT) begin
                            phase     <= PH_IDLE;
                            cmd       <= 1'b1;
                            xfer_done <= 1'b1;
                        end else begin
                            phase   <= PH_LOW;
                            bit_cnt <= bit_cnt + 3'd1;
                            psx_clk <= 1'b0;
                            cmd     <= tx_shift[1];
                        end
                    end else begin
                        phase_cnt <= phase_cnt + 1;
                    end
                end
                default: phase <= PH_IDLE;
            endcase
        end
    end

    // shift registers, lsb first in both directions
    always_ff @(posedge clk) begin
        if (phase == PH_IDLE && xfer_start) begin
            tx_shift <= tx_byte;
        end else if (next_bit) begin
            tx_shift <= {1'b1, tx_shift[7:1]};
        end
        if (clk_rise) begin
            rx_byte <= {data, rx_byte[7:1]};
        end
    end

endmodule

// File: design/psx_timing_pkg.sv
package psx_timing_pkg;

    // cycle counts for every timing parameter and counter
    typedef logic [31:0] cycles_t;

    // frame sequencer states
    typedef enum logic [2:0] {
        ST_BOOT,      // wait after reset
        ST_ATT_HIGH,  // att high between frames
        ST_ATT_LOW,   // att just lowered, first byte next
        ST_XFER,      // byte on the wire
        ST_ACK_WAIT   // window for the pad ack
    } poll_state_t;

endpackage

// File: design/psx_proto_pkg.sv
package psx_proto_pkg;

    // one byte on the pad link
    typedef logic [7:0] byte_t;

    // button state as the pad sends it, active low
    typedef logic [15:0] buttons_t;

    // bit position inside a byte, lsb first on the wire
    typedef logic [2:0] bit_idx_t;

    // byte position inside a poll frame
    typedef logic [2:0] slot_t;

    typedef struct packed {
        byte_t    pad_id;
        buttons_t buttons;  // low byte from frame byte 4
    } pad_report_t;

    localparam byte_t CMD_START = 8'h01;
    localparam byte_t CMD_POLL  = 8'h42;
    localparam byte_t CMD_IDLE  = 8'h00;

    localparam bit_idx_t LAST_BIT = 3'd7;

    // frame slots, counted from zero
    localparam slot_t SLOT_START  = 3'd0;
    localparam slot_t SLOT_ID     = 3'd1;  // pad answers 0x42 with its id
    localparam slot_t SLOT_BTN_LO = 3'd3;
    localparam slot_t LAST_SLOT   = 3'd4;  // high button byte, no ack after it

endpackage
